/* tb.f */
fpr_cdb_pkg.sv
cdb_res_if.sv
cdb_slot_if.sv
cdb_intake.sv
cdb_reservation_chain.sv
cdb_broadcast.sv
fpr_cdb.sv
tb_fpr_cdb.sv

/* Bender.yml */
package:
  name: fpr_cdb

sources:
  - fpr_cdb_pkg.sv
  - cdb_res_if.sv
  - cdb_slot_if.sv
  - cdb_intake.sv
  - cdb_reservation_chain.sv
  - cdb_broadcast.sv
  - fpr_cdb.sv
  - target: simulation
    files:
      - tb_fpr_cdb.sv

/* tb_fpr_cdb.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_fpr_cdb import fpr_cdb_pkg::*; ();

	// row kinds beyond the producer codes
	localparam int K_IN    = 7;
	localparam int K_RST   = 8;
	localparam int TIMEOUT = 40;

	typedef struct packed {
		logic [3:0] kind;
		tag_t       tag;
		logic       fsqrt;
		logic [7:0] hold;
		word_t      data;
	} row_t;

	logic  clk = 1'b0;
	logic  rst;
	logic  fdiv_valid, fdiv_is_fsqrt, fadd_valid, fmul_valid, itof_valid;
	logic  lw_valid, fmov_valid, in_valid;
	tag_t  fdiv_tag, fadd_tag, fmul_tag, itof_tag, lw_tag, fmov_tag, in_tag;
	logic  fadd_ready, fmul_ready, itof_ready, lw_ready, fmov_ready, in_ready;
	word_t in_data, result_fdiv, result_fsqrt, result_fadd, result_fmul;
	word_t result_itof, result_lw, result_fmov;
	logic  cdb_valid;
	tag_t  cdb_tag;
	word_t cdb_data;

	row_t       rows [$];
	int         seed = 98250;
	int         cycle = 0;
	int         n_logic = 0;
	int         n_tag = 0;
	int         n_word = 0;
	int         n_other = 0;
	int         n_acc = 0;
	int         n_bus = 0;
	int         n_flushed = 0;
	logic       timed_out = 1'b0;
	logic       rst_req;
	logic [7:0] pend_valid;
	tag_t       pend_tag [8];
	logic       pend_fsqrt;
	word_t      pend_data;

	// reference chain
	slot_mask_t m_valid;
	tag_t       m_tag [N_SLOT];
	unit_t      m_unit [N_SLOT];

	fpr_cdb i_dut (.*);

	always #5 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// stimulus and checks
	//////////////////////////////////////////////////////////////////////

	function automatic word_t result_value(input unit_t u, input int c);
		return {5'h18, u, 8'h5a, c[15:0]};
	endfunction

	task automatic check_logic(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
			n_logic++;
		end
	endtask

	task automatic check_tag(input string name, input tag_t exp, input tag_t act);
		if (act !== exp) begin
			$display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
			n_tag++;
		end
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
			n_word++;
		end
	endtask

	task automatic drive_inputs();
		rst           = rst_req;
		fdiv_valid    = pend_valid[UNIT_FDIV];
		fdiv_is_fsqrt = pend_fsqrt;
		fdiv_tag      = pend_tag[UNIT_FDIV];
		fadd_valid    = pend_valid[UNIT_FADD];
		fadd_tag      = pend_tag[UNIT_FADD];
		fmul_valid    = pend_valid[UNIT_FMUL];
		fmul_tag      = pend_tag[UNIT_FMUL];
		itof_valid    = pend_valid[UNIT_ITOF];
		itof_tag      = pend_tag[UNIT_ITOF];
		lw_valid      = pend_valid[UNIT_LW];
		lw_tag        = pend_tag[UNIT_LW];
		fmov_valid    = pend_valid[UNIT_FMOV];
		fmov_tag      = pend_tag[UNIT_FMOV];
		in_valid      = pend_valid[K_IN];
		in_tag        = pend_tag[K_IN];
		in_data       = pend_data;
		result_fdiv   = result_value(UNIT_FDIV, cycle);
		result_fsqrt  = result_value(UNIT_FSQRT, cycle);
		result_fadd   = result_value(UNIT_FADD, cycle);
		result_fmul   = result_value(UNIT_FMUL, cycle);
		result_itof   = result_value(UNIT_ITOF, cycle);
		result_lw     = result_value(UNIT_LW, cycle);
		result_fmov   = result_value(UNIT_FMOV, cycle);
	endtask

	task automatic merge(input int s, input logic take, input tag_t t, input unit_t u);
		if (take) begin
			m_valid[s] = 1'b1;
			m_tag[s]   = t;
			m_unit[s]  = u;
		end
	endtask

	// drives on the falling edge, then checks and advances the model
	task automatic step();
		logic [7:0] e_rdy;
		logic [7:0] acc;
		logic       e_valid;
		tag_t       e_tag;
		word_t      e_data;
		@(negedge clk);
		drive_inputs();
		#2;
		e_rdy            = '0;
		e_rdy[UNIT_FDIV] = 1'b1;
		e_rdy[UNIT_FADD] = !m_valid[6];
		e_rdy[UNIT_FMUL] = !m_valid[4];
		e_rdy[UNIT_ITOF] = !m_valid[3];
		e_rdy[UNIT_LW]   = !m_valid[1];
		e_rdy[UNIT_FMOV] = !m_valid[1] && !pend_valid[UNIT_LW];
		e_rdy[K_IN]      = !m_valid[0];
		acc = pend_valid & e_rdy;
		e_valid = m_valid[0] || acc[K_IN];
		e_tag   = m_valid[0] ? m_tag[0] : pend_tag[K_IN];
		e_data  = m_valid[0] ? result_value(m_unit[0], cycle) : pend_data;
		if (!rst) begin
			check_logic("fadd_ready", e_rdy[UNIT_FADD], fadd_ready);
			check_logic("fmul_ready", e_rdy[UNIT_FMUL], fmul_ready);
			check_logic("itof_ready", e_rdy[UNIT_ITOF], itof_ready);
			check_logic("lw_ready", e_rdy[UNIT_LW], lw_ready);
			check_logic("fmov_ready", e_rdy[UNIT_FMOV], fmov_ready);
			check_logic("in_ready", e_rdy[K_IN], in_ready);
			check_logic("cdb_valid", e_valid, cdb_valid);
			if (e_valid) begin
				check_tag("cdb_tag", e_tag, cdb_tag);
				check_word("cdb_data", e_data, cdb_data);
			end
			if (cdb_valid === 1'b1) begin
				n_bus++;
			end
		end
		@(posedge clk);
		cycle++;
		if (rst) begin
			n_flushed += $countones(m_valid);
			m_valid = '0;
		end else begin
			for (int i = 0; i < N_SLOT - 1; i++) begin
				m_valid[i] = m_valid[i+1];
				m_tag[i]   = m_tag[i+1];
				m_unit[i]  = m_unit[i+1];
			end
			m_valid[N_SLOT-1] = 1'b0;
			merge(SLOT_FDIV, acc[UNIT_FDIV], pend_tag[UNIT_FDIV],
				pend_fsqrt ? UNIT_FSQRT : UNIT_FDIV);
			merge(SLOT_FADD, acc[UNIT_FADD], pend_tag[UNIT_FADD], UNIT_FADD);
			merge(SLOT_FMUL, acc[UNIT_FMUL], pend_tag[UNIT_FMUL], UNIT_FMUL);
			merge(SLOT_ITOF, acc[UNIT_ITOF], pend_tag[UNIT_ITOF], UNIT_ITOF);
			merge(SLOT_LW, acc[UNIT_LW], pend_tag[UNIT_LW], UNIT_LW);
			merge(SLOT_FMOV, acc[UNIT_FMOV], pend_tag[UNIT_FMOV], UNIT_FMOV);
			n_acc += $countones(acc);
			pend_valid = pend_valid & ~acc;
		end
	endtask

	task automatic wait_free(input int k);
		int n;
		n = 0;
		while (pend_valid[k] && n < TIMEOUT) begin
			step();
			n++;
		end
		if (pend_valid[k]) begin
			$display("request of producer %0d was never accepted", k);
			timed_out = 1'b1;
			n_other++;
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while ((m_valid != '0 || pend_valid != '0) && n < TIMEOUT) begin
			step();
			n++;
		end
		if (m_valid != '0 || pend_valid != '0) begin
			$display("chain did not drain within %0d cycles", TIMEOUT);
			timed_out = 1'b1;
			n_other++;
		end
	endtask

	task automatic add_row(input int kind, input int tag, input logic fsqrt, input int hold);
		row_t r;
		r.kind  = kind[3:0];
		r.tag   = tag[4:0];
		r.fsqrt = fsqrt;
		r.hold  = hold[7:0];
		r.data  = $random(seed);
		rows.push_back(r);
	endtask

	task automatic apply_row(input row_t r);
		if (r.kind == K_RST) begin
			pend_valid = '0;
			rst_req    = 1'b1;
			repeat (r.hold) step();
			rst_req    = 1'b0;
		end else begin
			wait_free(r.kind);
			pend_valid[r.kind] = 1'b1;
			pend_tag[r.kind]   = r.tag;
			if (r.kind == UNIT_FDIV) begin
				pend_fsqrt = r.fsqrt;
			end
			if (r.kind == K_IN) begin
				pend_data = r.data;
			end
			repeat (r.hold) step();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// table
	//////////////////////////////////////////////////////////////////////

	initial begin
		// each producer alone
		add_row(UNIT_FDIV, 1, 1'b0, LAT_FDIV + 2);
		add_row(UNIT_FDIV, 2, 1'b1, LAT_FDIV + 2);
		add_row(UNIT_FADD, 3, 1'b0, LAT_FADD + 2);
		add_row(UNIT_FMUL, 4, 1'b0, LAT_FMUL + 2);
		add_row(UNIT_ITOF, 5, 1'b0, LAT_ITOF + 2);
		add_row(UNIT_LW, 6, 1'b0, LAT_LW + 2);
		add_row(UNIT_FMOV, 7, 1'b0, LAT_FMOV + 2);
		add_row(K_IN, 8, 1'b0, 3);
		// fdiv passing slots 6 and 4
		add_row(UNIT_FDIV, 9, 1'b0, 8);
		add_row(UNIT_FADD, 10, 1'b0, 2);
		add_row(UNIT_FMUL, 11, 1'b0, 20);
		// lw beats fmov, input port held off by slot 0
		add_row(UNIT_LW, 12, 1'b0, 0);
		add_row(UNIT_FMOV, 13, 1'b0, 4);
		add_row(UNIT_ITOF, 14, 1'b0, 2);
		add_row(K_IN, 15, 1'b0, 5);
		add_row(UNIT_LW, 16, 1'b0, 0);
		add_row(K_IN, 17, 1'b0, 3);
		// everything at once
		add_row(UNIT_FADD, 18, 1'b0, 0);
		add_row(UNIT_FMUL, 19, 1'b0, 0);
		add_row(UNIT_ITOF, 20, 1'b0, 0);
		add_row(UNIT_LW, 21, 1'b0, 0);
		add_row(UNIT_FMOV, 22, 1'b0, 0);
		add_row(K_IN, 23, 1'b0, 10);
		// 14 fdivs in flight
		for (int i = 0; i < N_SLOT; i++) begin
			add_row(UNIT_FDIV, i, i[0], (i == N_SLOT - 1) ? LAT_FDIV + 2 : 1);
		end
		// reset with entries in flight
		add_row(UNIT_FDIV, 24, 1'b0, 1);
		add_row(UNIT_FMUL, 25, 1'b0, 1);
		add_row(UNIT_FADD, 26, 1'b0, 2);
		add_row(K_RST, 0, 1'b0, 2);
		add_row(K_IN, 27, 1'b0, 2);
		add_row(UNIT_ITOF, 28, 1'b0, 6);

		pend_valid = '0;
		pend_fsqrt = 1'b0;
		pend_data  = '0;
		for (int k = 0; k < 8; k++) begin
			pend_tag[k] = '0;
		end
		m_valid = '0;
		rst_req = 1'b1;
		drive_inputs();
		repeat (5) step();
		rst_req = 1'b0;

		for (int r = 0; r < rows.size() && !timed_out; r++) begin
			apply_row(rows[r]);
		end
		if (!timed_out) begin
			wait_drained();
		end
		if (!timed_out && n_acc != n_bus + n_flushed) begin
			$display("bus results lost or duplicated: %0d accepted, %0d broadcast, %0d flushed",
				n_acc, n_bus, n_flushed);
			n_other++;
		end

		$display("errors: logic %0d, tag %0d, word %0d, other %0d",
			n_logic, n_tag, n_word, n_other);
		if (n_logic + n_tag + n_word + n_other == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* fpr_cdb.sv */
`timescale 1ns/100ps
`default_nettype none

module fpr_cdb import fpr_cdb_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  fdiv_valid,
	input  logic  fdiv_is_fsqrt,
	input  tag_t  fdiv_tag,
	input  logic  fadd_valid,
	input  tag_t  fadd_tag,
	output logic  fadd_ready,
	input  logic  fmul_valid,
	input  tag_t  fmul_tag,
	output logic  fmul_ready,
	input  logic  itof_valid,
	input  tag_t  itof_tag,
	output logic  itof_ready,
	input  logic  lw_valid,
	input  tag_t  lw_tag,
	output logic  lw_ready,
	input  logic  fmov_valid,
	input  tag_t  fmov_tag,
	output logic  fmov_ready,
	input  logic  in_valid,
	input  tag_t  in_tag,
	input  word_t in_data,
	output logic  in_ready,
	input  word_t result_fdiv,
	input  word_t result_fsqrt,
	input  word_t result_fadd,
	input  word_t result_fmul,
	input  word_t result_itof,
	input  word_t result_lw,
	input  word_t result_fmov,
	output logic  cdb_valid,
	output tag_t  cdb_tag,
	output word_t cdb_data
);

	logic in_accept;

	cdb_res_if  res ();
	cdb_slot_if slot ();

	cdb_intake i_intake (
		.fdiv_valid,
		.fdiv_is_fsqrt,
		.fadd_valid,
		.fmul_valid,
		.itof_valid,
		.lw_valid,
		.fmov_valid,
		.in_valid,
		.fdiv_tag,
		.fadd_tag,
		.fmul_tag,
		.itof_tag,
		.lw_tag,
		.fmov_tag,
		.fadd_ready,
		.fmul_ready,
		.itof_ready,
		.lw_ready,
		.fmov_ready,
		.in_ready,
		.in_accept,
		.res (res.intake)
	);

	cdb_reservation_chain i_chain (
		.clk,
		.rst,
		.res  (res.chain),
		.slot (slot.chain)
	);

	cdb_broadcast i_broadcast (
		.in_accept,
		.in_tag,
		.in_data,
		.result_fdiv,
		.result_fsqrt,
		.result_fadd,
		.result_fmul,
		.result_itof,
		.result_lw,
		.result_fmov,
		.slot (slot.broadcast),
		.cdb_valid,
		.cdb_tag,
		.cdb_data
	);

endmodule

`default_nettype wire

/* cdb_broadcast.sv */
`timescale 1ns/100ps
`default_nettype none

module cdb_broadcast import fpr_cdb_pkg::*; (
	input  logic  in_accept,
	input  tag_t  in_tag,
	input  word_t in_data,
	input  word_t result_fdiv,
	input  word_t result_fsqrt,
	input  word_t result_fadd,
	input  word_t result_fmul,
	input  word_t result_itof,
	input  word_t result_lw,
	input  word_t result_fmov,
	cdb_slot_if.broadcast slot,
	output logic  cdb_valid,
	output tag_t  cdb_tag,
	output word_t cdb_data
);

	assign cdb_valid = slot.valid || in_accept;
	assign cdb_tag   = slot.valid ? slot.tag : in_tag;

	//////////////////////////////////////////////////////////////////////
	// data select
	//////////////////////////////////////////////////////////////////////

	// producer presents its result in the cycle its entry hits slot 0
	always_comb begin
		if (!slot.valid) begin
			cdb_data = in_data;
		end else begin
			case (slot.unit)
				UNIT_FDIV:  cdb_data = result_fdiv;
				UNIT_FSQRT: cdb_data = result_fsqrt;
				UNIT_FADD:  cdb_data = result_fadd;
				UNIT_FMUL:  cdb_data = result_fmul;
				UNIT_ITOF:  cdb_data = result_itof;
				UNIT_LW:    cdb_data = result_lw;
				UNIT_FMOV:  cdb_data = result_fmov;
				default:    cdb_data = '0;
			endcase
		end
	end

	// bus is never driven by both slot 0 and the input port
	always_comb begin
		a_in_vs_slot0: assert final (!(in_accept && slot.valid));
	end

endmodule

`default_nettype wire

/* cdb_reservation_chain.sv */
`timescale 1ns/100ps
`default_nettype none

module cdb_reservation_chain import fpr_cdb_pkg::*; (
	input logic clk,
	input logic rst,
	cdb_res_if.chain res,
	cdb_slot_if.chain slot
);

	slot_mask_t slot_valid;
	tag_t       slot_tag [N_SLOT];
	unit_t      slot_unit [N_SLOT];

	// what shifts into each slot from above
	slot_mask_t above_valid;

	slot_mask_t load;
	tag_t       load_tag [N_SLOT];
	unit_t      load_unit [N_SLOT];

	assign above_valid = {1'b0, slot_valid[N_SLOT-1:1]};

	//////////////////////////////////////////////////////////////////////
	// merge points
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		load = '0;
		for (int i = 0; i < N_SLOT; i++) begin
			load_tag[i]  = '0;
			load_unit[i] = UNIT_FDIV;
		end
		if (res.fdiv_accept) begin
			load[SLOT_FDIV]      = 1'b1;
			load_tag[SLOT_FDIV]  = res.fdiv_tag;
			load_unit[SLOT_FDIV] = res.fdiv_is_fsqrt ? UNIT_FSQRT : UNIT_FDIV;
		end
		if (res.fadd_accept) begin
			load[SLOT_FADD]      = 1'b1;
			load_tag[SLOT_FADD]  = res.fadd_tag;
			load_unit[SLOT_FADD] = UNIT_FADD;
		end
		if (res.fmul_accept) begin
			load[SLOT_FMUL]      = 1'b1;
			load_tag[SLOT_FMUL]  = res.fmul_tag;
			load_unit[SLOT_FMUL] = UNIT_FMUL;
		end
		if (res.itof_accept) begin
			load[SLOT_ITOF]      = 1'b1;
			load_tag[SLOT_ITOF]  = res.itof_tag;
			load_unit[SLOT_ITOF] = UNIT_ITOF;
		end
		// lw written last so it wins over fmov
		if (res.fmov_accept) begin
			load[SLOT_FMOV]      = 1'b1;
			load_tag[SLOT_FMOV]  = res.fmov_tag;
			load_unit[SLOT_FMOV] = UNIT_FMOV;
		end
		if (res.lw_accept) begin
			load[SLOT_LW]      = 1'b1;
			load_tag[SLOT_LW]  = res.lw_tag;
			load_unit[SLOT_LW] = UNIT_LW;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// shift register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_valid <= '0;
		end else begin
			slot_valid <= above_valid | load;
		end
	end

	// entry moving down has priority over a new request
	always_ff @(posedge clk) begin
		for (int i = 0; i < N_SLOT - 1; i++) begin
			if (slot_valid[i+1]) begin
				slot_tag[i]  <= slot_tag[i+1];
				slot_unit[i] <= slot_unit[i+1];
			end else begin
				slot_tag[i]  <= load_tag[i];
				slot_unit[i] <= load_unit[i];
			end
		end
		slot_tag[N_SLOT-1]  <= load_tag[N_SLOT-1];
		slot_unit[N_SLOT-1] <= load_unit[N_SLOT-1];
	end

	assign res.occupancy = slot_valid;

	assign slot.valid = slot_valid[0];
	assign slot.tag   = slot_tag[0];
	assign slot.unit  = slot_unit[0];

	// intake ready must have kept every merge collision-free
	a_no_merge_collision: assert property (
		@(posedge clk) disable iff (rst) (load & above_valid) == '0
	);

	// slot 0 has one merge port for lw and fmov
	a_lw_fmov_excl: assert property (
		@(posedge clk) disable iff (rst) !(res.lw_accept && res.fmov_accept)
	);

	a_empty_after_rst: assert property (
		@(posedge clk) rst |=> res.occupancy == '0
	);

endmodule

`default_nettype wire

/* cdb_intake.sv */
`timescale 1ns/100ps
`default_nettype none

module cdb_intake import fpr_cdb_pkg::*; (
	input  logic fdiv_valid,
	input  logic fdiv_is_fsqrt,
	input  logic fadd_valid,
	input  logic fmul_valid,
	input  logic itof_valid,
	input  logic lw_valid,
	input  logic fmov_valid,
	input  logic in_valid,
	input  tag_t fdiv_tag,
	input  tag_t fadd_tag,
	input  tag_t fmul_tag,
	input  tag_t itof_tag,
	input  tag_t lw_tag,
	input  tag_t fmov_tag,
	output logic fadd_ready,
	output logic fmul_ready,
	output logic itof_ready,
	output logic lw_ready,
	output logic fmov_ready,
	output logic in_ready,
	output logic in_accept,
	cdb_res_if.intake res
);

	//////////////////////////////////////////////////////////////////////
	// ready
	//////////////////////////////////////////////////////////////////////

	// a producer may enter only if nothing is about to shift into its slot
	assign fadd_ready = !res.occupancy[SLOT_FADD+1];
	assign fmul_ready = !res.occupancy[SLOT_FMUL+1];
	assign itof_ready = !res.occupancy[SLOT_ITOF+1];
	assign lw_ready   = !res.occupancy[SLOT_LW+1];

	// fmov yields to lw at the shared slot
	assign fmov_ready = !res.occupancy[SLOT_FMOV+1] && !lw_valid;

	// input port needs the bus itself this cycle
	assign in_ready  = !res.occupancy[0];
	assign in_accept = in_valid && in_ready;

	//////////////////////////////////////////////////////////////////////
	// accept strobes
	//////////////////////////////////////////////////////////////////////

	// nothing can sit above the top slot
	assign res.fdiv_accept   = fdiv_valid;
	assign res.fdiv_is_fsqrt = fdiv_is_fsqrt;

	assign res.fadd_accept = fadd_valid && fadd_ready;
	assign res.fmul_accept = fmul_valid && fmul_ready;
	assign res.itof_accept = itof_valid && itof_ready;
	assign res.lw_accept   = lw_valid && lw_ready;
	assign res.fmov_accept = fmov_valid && fmov_ready;

	assign res.fdiv_tag = fdiv_tag;
	assign res.fadd_tag = fadd_tag;
	assign res.fmul_tag = fmul_tag;
	assign res.itof_tag = itof_tag;
	assign res.lw_tag   = lw_tag;
	assign res.fmov_tag = fmov_tag;

endmodule

`default_nettype wire

/* cdb_slot_if.sv */
`timescale 1ns/100ps
`default_nettype none

// reservation currently at slot 0
interface cdb_slot_if import fpr_cdb_pkg::*; ();

	logic  valid;
	tag_t  tag;
	unit_t unit;

	modport chain (
		output valid,
		output tag,
		output unit
	);

	modport broadcast (
		input valid,
		input tag,
		input unit
	);

endinterface

`default_nettype wire

/* cdb_res_if.sv */
`timescale 1ns/100ps
`default_nettype none

// accepted requests from intake, occupancy back from the chain
interface cdb_res_if import fpr_cdb_pkg::*; ();

	logic fdiv_accept;
	logic fdiv_is_fsqrt;
	logic fadd_accept;
	logic fmul_accept;
	logic itof_accept;
	logic lw_accept;
	logic fmov_accept;

	tag_t fdiv_tag;
	tag_t fadd_tag;
	tag_t fmul_tag;
	tag_t itof_tag;
	tag_t lw_tag;
	tag_t fmov_tag;

	slot_mask_t occupancy;

	modport intake (
		output fdiv_accept, fdiv_is_fsqrt, fadd_accept, fmul_accept,
		output itof_accept, lw_accept, fmov_accept,
		output fdiv_tag, fadd_tag, fmul_tag, itof_tag, lw_tag, fmov_tag,
		input  occupancy
	);

	modport chain (
		input  fdiv_accept, fdiv_is_fsqrt, fadd_accept, fmul_accept,
		input  itof_accept, lw_accept, fmov_accept,
		input  fdiv_tag, fadd_tag, fmul_tag, itof_tag, lw_tag, fmov_tag,
		output occupancy
	);

endinterface

`default_nettype wire

/* fpr_cdb_pkg.sv */
`default_nettype none

package fpr_cdb_pkg;

	////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////

	localparam int ROB_WIDTH  = 5;
	localparam int WORD_WIDTH = 32;
	localparam int UNIT_WIDTH = 3;
	localparam int N_SLOT     = 14;

	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [ROB_WIDTH-1:0]  tag_t;
	typedef logic [UNIT_WIDTH-1:0] unit_t;
	typedef logic [N_SLOT-1:0]     slot_mask_t;

	////////////////////////////////////////////////////////////////////
	// producer codes
	////////////////////////////////////////////////////////////////////

	localparam unit_t UNIT_FDIV  = 3'd0;
	localparam unit_t UNIT_FSQRT = 3'd1;
	localparam unit_t UNIT_FADD  = 3'd2;
	localparam unit_t UNIT_FMUL  = 3'd3;
	localparam unit_t UNIT_ITOF  = 3'd4;
	localparam unit_t UNIT_LW    = 3'd5;
	localparam unit_t UNIT_FMOV  = 3'd6;

	// fdiv and fsqrt share one entry slot
	localparam int SLOT_FDIV = 13;
	localparam int SLOT_FADD = 5;
	localparam int SLOT_FMUL = 3;
	localparam int SLOT_ITOF = 2;
	localparam int SLOT_LW   = 0;
	localparam int SLOT_FMOV = 0;

	// cycles from accept to bus
	localparam int LAT_FDIV = SLOT_FDIV + 1;
	localparam int LAT_FADD = SLOT_FADD + 1;
	localparam int LAT_FMUL = SLOT_FMUL + 1;
	localparam int LAT_ITOF = SLOT_ITOF + 1;
	localparam int LAT_LW   = SLOT_LW + 1;
	localparam int LAT_FMOV = SLOT_FMOV + 1;

endpackage

`default_nettype wire
